// File: sources.f
hw/mem_map_pkg.sv
hw/addr_decode.sv
hw/led_bank.sv
hw/uart_tx.sv
hw/pixel_writer.sv
hw/mem_map_ctrl.sv
hw/mem_map_top.sv
tests/tb_mem_map.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_mem_map -f sources.f -o sim_mem_map

./obj_dir/sim_mem_map | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
exit 0

// File: tests/tb_mem_map.sv
`default_nettype none

module tb_mem_map;

    localparam int num_txns      = 300;
    localparam int watchdog_time = num_txns * 60 * 20;

    logic        clk = 1'b0;
    logic        rst;
    logic [15:0] pc;
    logic [15:0] data_addr;
    logic [15:0] data_in;
    logic        write_en;
    logic        cpu_ready;
    logic [15:0] dram_rdata = 16'h0000;
    logic        dram_ack = 1'b0;
    logic [15:0] instr;
    logic [15:0] read_data;
    logic        instr_valid;
    logic        data_valid;
    logic [9:0]  led;
    logic        uart_txd;
    logic        dram_req;
    logic        dram_we;
    logic [24:0] dram_addr;
    logic [15:0] dram_wdata;

    integer      seed = 32'hb5f96643;
    int          mismatches = 0;
    int          failures = 0;
    int          txn_count = 0;

    // dram contents and the reference model
    logic [15:0] dram_mem [logic [24:0]];
    logic [15:0] model_mem [logic [24:0]];
    logic [9:0]  model_led;
    int          model_phase;
    logic [9:0]  model_x;
    logic [8:0]  model_y;
    logic [7:0]  exp_bytes [$];
    logic [24:0] acc_addr [$];
    logic        acc_we [$];
    logic [15:0] acc_wdata [$];

    logic        req_pending;
    int          ack_wait;
    logic [24:0] req_addr;
    logic        req_we;
    logic [15:0] req_wdata;
    logic [15:0] last_read;
    logic [7:0]  rx_byte;
    int          rx_bit;
    int          sel;
    logic [15:0] a_v;
    logic [15:0] d_v;
    logic        w_v;

    mem_map_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .data_addr   (data_addr),
        .data_in     (data_in),
        .write_en    (write_en),
        .cpu_ready   (cpu_ready),
        .dram_rdata  (dram_rdata),
        .dram_ack    (dram_ack),
        .instr       (instr),
        .read_data   (read_data),
        .instr_valid (instr_valid),
        .data_valid  (data_valid),
        .led         (led),
        .uart_txd    (uart_txd),
        .dram_req    (dram_req),
        .dram_we     (dram_we),
        .dram_addr   (dram_addr),
        .dram_wdata  (dram_wdata)
    );

    always #10 clk = ~clk;

    function automatic logic [15:0] rand16();
        logic [31:0] r;
        r = $random(seed);
        rand16 = r[15:0];
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        rand_below = int'(r % 32'(n));
    endfunction

    // unwritten words depend on every address bit
    function automatic logic [15:0] fill_word(input logic [24:0] a);
        fill_word = a[15:0] ^ {7'b0, a[24:16]} ^ 16'hc3a5;
    endfunction

    function automatic logic [15:0] model_read(input logic [24:0] a);
        if (model_mem.exists(a)) begin
            model_read = model_mem[a];
        end else begin
            model_read = fill_word(a);
        end
    endfunction

    function automatic logic [15:0] new_pc();
        logic [15:0] v;
        v = rand16() & 16'h00ff;
        if (v == pc) begin
            v = v ^ 16'h0001;
        end
        new_pc = v;
    endfunction

    // above the dram window, never ffff
    function automatic logic [15:0] far_pc();
        logic [15:0] v;
        v = 16'hF801 + 16'(rand_below(2046));
        if (v == pc) begin
            v = v - 16'd1;
        end
        far_pc = v;
    endfunction

    task automatic report_mismatch(input string msg);
        mismatches++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        failures++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    // dram with 1 to 4 cycles of ack latency
    always @(posedge clk) begin
        dram_ack <= 1'b0;
        if (!rst) begin
            req_pending = 1'b0;
        end else begin
            if (dram_req) begin
                if (req_pending) begin
                    report_failure("dram_req strobed again before dram_ack");
                end
                req_pending = 1'b1;
                req_addr    = dram_addr;
                req_we      = dram_we;
                req_wdata   = dram_wdata;
                ack_wait    = rand_below(4);
                acc_addr.push_back(dram_addr);
                acc_we.push_back(dram_we);
                acc_wdata.push_back(dram_wdata);
            end
            if (req_pending) begin
                if (ack_wait == 0) begin
                    if (req_we) begin
                        dram_mem[req_addr] = req_wdata;
                    end
                    if (dram_mem.exists(req_addr)) begin
                        dram_rdata <= dram_mem[req_addr];
                    end else begin
                        dram_rdata <= fill_word(req_addr);
                    end
                    dram_ack    <= 1'b1;
                    req_pending = 1'b0;
                end else begin
                    ack_wait = ack_wait - 1;
                end
            end
        end
    end

    // serial line decoder, first low sample is about one clock into the start bit
    always begin
        @(posedge clk);
        if (rst === 1'b1 && uart_txd === 1'b0) begin
            repeat (mem_map_pkg::clks_per_bit / 2 - 1) @(posedge clk);
            if (uart_txd !== 1'b0) begin
                report_failure("uart start bit too short");
            end
            for (rx_bit = 0; rx_bit < 8; rx_bit++) begin
                repeat (mem_map_pkg::clks_per_bit) @(posedge clk);
                rx_byte[rx_bit] = uart_txd;
            end
            repeat (mem_map_pkg::clks_per_bit) @(posedge clk);
            if (uart_txd !== 1'b1) begin
                report_failure("uart stop bit missing");
            end
            if (exp_bytes.size() == 0) begin
                report_failure($sformatf("uart byte %h sent with none expected", rx_byte));
            end else if (rx_byte !== exp_bytes[0]) begin
                report_mismatch($sformatf("uart byte %h, expected %h", rx_byte, exp_bytes[0]));
                void'(exp_bytes.pop_front());
            end else begin
                void'(exp_bytes.pop_front());
            end
        end
    end

    // called just after a rising edge
    task automatic run_txn(input logic [15:0] pc_val, input logic [15:0] addr,
                           input logic [15:0] din, input logic we, input logic drop_ready);
        logic [24:0] fetch_addr;
        logic [24:0] exp_addr;
        logic        exp_we;
        logic [15:0] exp_instr;
        logic [15:0] exp_read;
        int          instr_seen;
        fetch_addr = (pc_val <= mem_map_pkg::dram_last) ? {9'b0, pc_val} : 25'b0;
        exp_instr  = model_read(fetch_addr);
        exp_addr   = 25'b0;
        exp_we     = 1'b0;
        if (addr <= mem_map_pkg::dram_last) begin
            exp_addr = {9'b0, addr};
            exp_we   = we;
        end else if (we && addr >= mem_map_pkg::led_first && addr <= mem_map_pkg::led_last) begin
            model_led[4'(addr - mem_map_pkg::led_first)] = din[0];
        end else if (we && addr == mem_map_pkg::vga_addr) begin
            case (model_phase)
                0: model_x = din[9:0];
                1: model_y = din[8:0];
                default: begin
                    exp_addr = {6'b0, model_x, model_y};
                    exp_we   = 1'b1;
                end
            endcase
            model_phase = (model_phase + 1) % 3;
        end
        if (exp_we) begin
            model_mem[exp_addr] = din;
        end
        exp_read = model_read(exp_addr);

        pc        <= pc_val;
        data_addr <= addr;
        data_in   <= din;
        write_en  <= we;
        if (drop_ready) begin
            cpu_ready <= 1'b0;
            @(posedge clk);
        end
        cpu_ready <= 1'b1;
        instr_seen = 0;
        do begin
            @(posedge clk);
            if (instr_valid) begin
                instr_seen++;
                if (instr !== exp_instr) begin
                    report_mismatch($sformatf("instr %h for pc %h, expected %h",
                                              instr, pc_val, exp_instr));
                end
            end
        end while (!data_valid);

        if (instr_seen != 1) begin
            report_failure($sformatf("%0d instr_valid strobes for pc %h", instr_seen, pc_val));
        end
        if (addr == mem_map_pkg::uart_ready_addr) begin
            if (read_data[15:1] !== 15'h0) begin
                report_mismatch($sformatf("uart ready read %h, expected 0 or 1", read_data));
            end
            last_read = read_data;
        end else if (read_data !== exp_read) begin
            report_mismatch($sformatf("read_data %h at %h, expected %h",
                                      read_data, addr, exp_read));
        end
        if (led !== model_led) begin
            report_mismatch($sformatf("led %b, expected %b", led, model_led));
        end
        if (acc_addr.size() != 2) begin
            report_failure($sformatf("%0d dram requests in one transaction instead of 2",
                                     acc_addr.size()));
        end else begin
            if (acc_addr[0] !== fetch_addr || acc_we[0] !== 1'b0) begin
                report_mismatch($sformatf("fetch at %h we %b, expected read at %h",
                                          acc_addr[0], acc_we[0], fetch_addr));
            end
            if (acc_addr[1] !== exp_addr || acc_we[1] !== exp_we) begin
                report_mismatch($sformatf("data access at %h we %b, expected %h we %b",
                                          acc_addr[1], acc_we[1], exp_addr, exp_we));
            end else if (exp_we && acc_wdata[1] !== din) begin
                report_mismatch($sformatf("dram write data %h, expected %h", acc_wdata[1], din));
            end
        end
        acc_addr.delete();
        acc_we.delete();
        acc_wdata.delete();
        txn_count++;
    endtask

    task automatic check_no_refetch();
        repeat (8) begin
            @(posedge clk);
            if (instr_valid || dram_req) begin
                report_failure("unchanged pc started another transaction");
            end
        end
    endtask

    task automatic uart_sequence();
        logic [15:0] byte_word;
        last_read = 16'h0;
        while (last_read[0] !== 1'b1) begin
            run_txn(new_pc(), mem_map_pkg::uart_ready_addr, rand16(), 1'b0, 1'b0);
        end
        byte_word = rand16();
        exp_bytes.push_back(byte_word[7:0]);
        run_txn(new_pc(), mem_map_pkg::uart_byte_addr, byte_word, 1'b1, 1'b0);
        run_txn(new_pc(), mem_map_pkg::uart_ready_addr, rand16(), 1'b0, 1'b0);
        if (last_read !== 16'h0) begin
            report_mismatch($sformatf("uart ready %h right after a byte write, expected 0",
                                      last_read));
        end
        // transmitter still busy, so this byte is dropped
        run_txn(new_pc(), mem_map_pkg::uart_byte_addr, rand16(), 1'b1, 1'b0);
    endtask

    initial begin
        rst         = 1'b0;
        pc          = 16'h0000;
        data_addr   = 16'h0000;
        data_in     = 16'h0000;
        write_en    = 1'b0;
        cpu_ready   = 1'b0;
        model_led   = 10'b0;
        model_phase = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        repeat (3) begin
            @(posedge clk);
            if (instr_valid !== 1'b0 || data_valid !== 1'b0 || dram_req !== 1'b0) begin
                report_failure("strobe active in the idle cycles after reset");
            end
            if (instr !== mem_map_pkg::nop_instr || led !== 10'b0 || uart_txd !== 1'b1) begin
                report_mismatch($sformatf("after reset instr %h led %b txd %b",
                                          instr, led, uart_txd));
            end
        end

        while (txn_count < num_txns) begin
            sel = rand_below(10);
            a_v = rand16() & 16'h00ff;
            d_v = rand16();
            w_v = (rand_below(2) == 1);
            case (sel)
                0, 1, 2: run_txn(new_pc(), a_v, d_v, w_v, 1'b0);
                3: run_txn(new_pc(), mem_map_pkg::led_first + 16'(rand_below(10)), d_v, w_v, 1'b0);
                4: uart_sequence();
                5: begin
                    repeat (3) run_txn(new_pc(), mem_map_pkg::vga_addr, rand16(), 1'b1, 1'b0);
                end
                6: run_txn(new_pc(), 16'hF80D + 16'(rand_below(2035)), d_v, w_v, 1'b0);
                7: begin
                    check_no_refetch();
                    run_txn(new_pc(), a_v, d_v, w_v, 1'b0);
                end
                8: run_txn(pc, a_v, d_v, w_v, 1'b1);
                default: run_txn(far_pc(), a_v, d_v, 1'b0, 1'b0);
            endcase
        end

        // let the last frame finish
        repeat (12 * mem_map_pkg::clks_per_bit) @(posedge clk);
        if (exp_bytes.size() != 0) begin
            report_failure($sformatf("%0d uart bytes never appeared on uart_txd",
                                     exp_bytes.size()));
        end
        $display("%0d mismatches, %0d other errors, %0d transactions",
                 mismatches, failures, txn_count);
        if (mismatches + failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(watchdog_time);
        report_failure("timeout, the transactions did not complete");
        $display("%0d mismatches, %0d other errors, %0d transactions",
                 mismatches, failures, txn_count);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/mem_map_top.sv
`default_nettype none

module mem_map_top (
    input  wire                                       clk,
    input  wire                                       rst,
    input  wire [mem_map_pkg::word_width-1:0]         pc,
    input  wire [mem_map_pkg::word_width-1:0]         data_addr,
    input  wire [mem_map_pkg::word_width-1:0]         data_in,
    input  wire                                       write_en,
    input  wire                                       cpu_ready,
    input  wire [mem_map_pkg::word_width-1:0]         dram_rdata,
    input  wire                                       dram_ack,
    output logic [mem_map_pkg::word_width-1:0]        instr,
    output logic [mem_map_pkg::word_width-1:0]        read_data,
    output logic                                      instr_valid,
    output logic                                      data_valid,
    output logic [mem_map_pkg::led_count-1:0]         led,
    output logic                                      uart_txd,
    output logic                                      dram_req,
    output logic                                      dram_we,
    output logic [mem_map_pkg::dram_addr_width-1:0]   dram_addr,
    output logic [mem_map_pkg::word_width-1:0]        dram_wdata
);

    mem_map_pkg::region_t                          data_region;
    logic [mem_map_pkg::led_index_width-1:0]       led_index;
    logic                                          dev_write;
    logic                                          led_wr;
    logic                                          uart_start;
    logic                                          uart_ready;
    logic                                          pixel_wr;
    logic                                          pixel_commit;
    logic [mem_map_pkg::pixel_addr_width-1:0]      pixel_addr;

    // device write strobes
    assign led_wr     = dev_write && write_en && (data_region == mem_map_pkg::led);
    assign uart_start = dev_write && write_en && (data_region == mem_map_pkg::uart_byte);
    assign pixel_wr   = dev_write && write_en && (data_region == mem_map_pkg::vga);

    mem_map_ctrl i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_ready    (cpu_ready),
        .pc           (pc),
        .data_addr    (data_addr),
        .data_in      (data_in),
        .write_en     (write_en),
        .dram_rdata   (dram_rdata),
        .dram_ack     (dram_ack),
        .data_region  (data_region),
        .uart_ready   (uart_ready),
        .pixel_commit (pixel_commit),
        .pixel_addr   (pixel_addr),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .read_data    (read_data),
        .data_valid   (data_valid),
        .dram_req     (dram_req),
        .dram_we      (dram_we),
        .dram_addr    (dram_addr),
        .dram_wdata   (dram_wdata),
        .dev_write    (dev_write)
    );

    addr_decode i_decode (
        .addr      (data_addr),
        .region    (data_region),
        .led_index (led_index)
    );

    led_bank i_leds (
        .clk    (clk),
        .rst    (rst),
        .wr     (led_wr),
        .index  (led_index),
        .bit_in (data_in[0]),
        .led    (led)
    );

    uart_tx i_uart (
        .clk     (clk),
        .rst     (rst),
        .start   (uart_start),
        .tx_byte (data_in[mem_map_pkg::uart_data_bits-1:0]),
        .ready   (uart_ready),
        .txd     (uart_txd)
    );

    pixel_writer i_pixel (
        .clk        (clk),
        .rst        (rst),
        .wr         (pixel_wr),
        .data       (data_in),
        .commit     (pixel_commit),
        .pixel_addr (pixel_addr)
    );

endmodule

`default_nettype wire

// File: hw/mem_map_ctrl.sv
`default_nettype none

module mem_map_ctrl (
    input  wire                                       clk,
    input  wire                                       rst,
    input  wire                                       cpu_ready,
    input  wire [mem_map_pkg::word_width-1:0]         pc,
    input  wire [mem_map_pkg::word_width-1:0]         data_addr,
    input  wire [mem_map_pkg::word_width-1:0]         data_in,
    input  wire                                       write_en,
    input  wire [mem_map_pkg::word_width-1:0]         dram_rdata,
    input  wire                                       dram_ack,
    input  wire mem_map_pkg::region_t                 data_region,
    input  wire                                       uart_ready,
    input  wire                                       pixel_commit,
    input  wire [mem_map_pkg::pixel_addr_width-1:0]   pixel_addr,
    output logic [mem_map_pkg::word_width-1:0]        instr,
    output logic                                      instr_valid,
    output logic [mem_map_pkg::word_width-1:0]        read_data,
    output logic                                      data_valid,
    output logic                                      dram_req,
    output logic                                      dram_we,
    output logic [mem_map_pkg::dram_addr_width-1:0]   dram_addr,
    output logic [mem_map_pkg::word_width-1:0]        dram_wdata,
    output logic                                      dev_write
);

    mem_map_pkg::ctrl_state_t                  state;
    logic [mem_map_pkg::word_width-1:0]        last_pc;
    logic                                      start;

    // request chosen in the strobe cycle, then held until the ack
    logic [mem_map_pkg::dram_addr_width-1:0]   sel_addr;
    logic                                      sel_we;
    logic [mem_map_pkg::word_width-1:0]        sel_wdata;
    logic [mem_map_pkg::dram_addr_width-1:0]   hold_addr;
    logic                                      hold_we;
    logic [mem_map_pkg::word_width-1:0]        hold_wdata;

    assign start     = cpu_ready && (pc != last_pc);
    assign dram_req  = (state == mem_map_pkg::fetch_instr) || (state == mem_map_pkg::rw_data);
    assign dev_write = (state == mem_map_pkg::rw_data);

    always_comb begin
        sel_addr  = '0;
        sel_we    = 1'b0;
        sel_wdata = data_in;
        if (state == mem_map_pkg::fetch_instr) begin
            // out-of-window pc fetches word 0
            if (pc <= mem_map_pkg::dram_last) begin
                sel_addr = {{mem_map_pkg::dram_pad_width{1'b0}}, pc};
            end
        end else if (pixel_commit) begin
            sel_addr = {{mem_map_pkg::pixel_pad_width{1'b0}}, pixel_addr};
            sel_we   = 1'b1;
        end else if (data_region == mem_map_pkg::dram) begin
            sel_addr = {{mem_map_pkg::dram_pad_width{1'b0}}, data_addr};
            sel_we   = write_en;
        end
    end

    assign dram_addr  = dram_req ? sel_addr : hold_addr;
    assign dram_we    = dram_req ? sel_we : hold_we;
    assign dram_wdata = dram_req ? sel_wdata : hold_wdata;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state       <= mem_map_pkg::idle;
            last_pc     <= '1;
            instr       <= mem_map_pkg::nop_instr;
            instr_valid <= 1'b0;
            data_valid  <= 1'b0;
            hold_we     <= 1'b0;
        end else begin
            instr_valid <= 1'b0;
            data_valid  <= 1'b0;
            if (dram_req) begin
                hold_we <= sel_we;
            end
            // cpu not ready, so the next ready refetches
            if (!cpu_ready) begin
                last_pc <= '1;
            end
            case (state)
                mem_map_pkg::idle: begin
                    if (start) begin
                        last_pc <= pc;
                        state   <= mem_map_pkg::fetch_instr;
                    end
                end
                mem_map_pkg::fetch_instr: state <= mem_map_pkg::wait_instr;
                mem_map_pkg::wait_instr: begin
                    if (dram_ack) begin
                        instr       <= dram_rdata;
                        instr_valid <= 1'b1;
                        state       <= mem_map_pkg::instr_out;
                    end
                end
                mem_map_pkg::instr_out: state <= mem_map_pkg::rw_data;
                mem_map_pkg::rw_data:   state <= mem_map_pkg::wait_data;
                mem_map_pkg::wait_data: begin
                    if (dram_ack) begin
                        data_valid <= 1'b1;
                        state      <= mem_map_pkg::data_out;
                    end
                end
                mem_map_pkg::data_out: state <= mem_map_pkg::idle;
                default:               state <= mem_map_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dram_req) begin
            hold_addr  <= sel_addr;
            hold_wdata <= sel_wdata;
        end
        if (state == mem_map_pkg::wait_data && dram_ack) begin
            if (data_region == mem_map_pkg::uart_ready) begin
                read_data <= {{(mem_map_pkg::word_width - 1){1'b0}}, uart_ready};
            end else begin
                read_data <= dram_rdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/pixel_writer.sv
`default_nettype none

module pixel_writer (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire                                        wr,
    input  wire [mem_map_pkg::word_width-1:0]          data,
    output logic                                       commit,
    output logic [mem_map_pkg::pixel_addr_width-1:0]   pixel_addr
);

    mem_map_pkg::pixel_state_t               phase;
    logic [mem_map_pkg::px_x_width-1:0]      x_reg;
    logic [mem_map_pkg::px_y_width-1:0]      y_reg;

    // colour write goes straight to dram in the same cycle
    assign commit     = wr && (phase == mem_map_pkg::px_colour);
    assign pixel_addr = {x_reg, y_reg};

    always_ff @(posedge clk) begin
        if (!rst) begin
            phase <= mem_map_pkg::px_x;
        end else if (wr) begin
            case (phase)
                mem_map_pkg::px_x:      phase <= mem_map_pkg::px_y;
                mem_map_pkg::px_y:      phase <= mem_map_pkg::px_colour;
                mem_map_pkg::px_colour: phase <= mem_map_pkg::px_x;
                default:                phase <= mem_map_pkg::px_x;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr && phase == mem_map_pkg::px_x) begin
            x_reg <= data[mem_map_pkg::px_x_width-1:0];
        end
        if (wr && phase == mem_map_pkg::px_y) begin
            y_reg <= data[mem_map_pkg::px_y_width-1:0];
        end
    end

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`default_nettype none

module uart_tx (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire                                      start,
    input  wire [mem_map_pkg::uart_data_bits-1:0]    tx_byte,
    output logic                                     ready,
    output logic                                     txd
);

    logic                                         busy;
    logic [mem_map_pkg::baud_cnt_width-1:0]       clk_cnt;
    logic [3:0]                                   bit_cnt;
    // data bits then stop bit, shifted out lsb first
    logic [mem_map_pkg::uart_data_bits:0]         frame;

    assign ready = !busy;

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy    <= 1'b0;
            txd     <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!busy) begin
            if (start) begin
                busy    <= 1'b1;
                txd     <= 1'b0;
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (clk_cnt == mem_map_pkg::baud_cnt_width'(mem_map_pkg::clks_per_bit - 1)) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'(mem_map_pkg::uart_data_bits + 1)) begin
                // end of stop bit
                busy <= 1'b0;
                txd  <= 1'b1;
            end else begin
                txd     <= frame[0];
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && start) begin
            frame <= {1'b1, tx_byte};
        end else if (busy && clk_cnt == mem_map_pkg::baud_cnt_width'(mem_map_pkg::clks_per_bit - 1)) begin
            frame <= {1'b1, frame[mem_map_pkg::uart_data_bits:1]};
        end
    end

endmodule

`default_nettype wire

// File: hw/led_bank.sv
`default_nettype none

module led_bank (
    input  wire                                       clk,
    input  wire                                       rst,
    input  wire                                       wr,
    input  wire [mem_map_pkg::led_index_width-1:0]    index,
    input  wire                                       bit_in,
    output logic [mem_map_pkg::led_count-1:0]         led
);

    always_ff @(posedge clk) begin
        if (!rst) begin
            led <= '0;
        end else if (wr && index < mem_map_pkg::led_count) begin
            // one bit per address
            led[index] <= bit_in;
        end
    end

endmodule

`default_nettype wire

// File: hw/addr_decode.sv
`default_nettype none

module addr_decode (
    input  wire [mem_map_pkg::word_width-1:0]        addr,
    output mem_map_pkg::region_t                     region,
    output logic [mem_map_pkg::led_index_width-1:0]  led_index
);

    always_comb begin
        if (addr <= mem_map_pkg::dram_last) begin
            region = mem_map_pkg::dram;
        end else if (addr >= mem_map_pkg::led_first && addr <= mem_map_pkg::led_last) begin
            region = mem_map_pkg::led;
        end else if (addr == mem_map_pkg::uart_ready_addr) begin
            region = mem_map_pkg::uart_ready;
        end else if (addr == mem_map_pkg::uart_byte_addr) begin
            region = mem_map_pkg::uart_byte;
        end else if (addr == mem_map_pkg::vga_addr) begin
            region = mem_map_pkg::vga;
        end else begin
            region = mem_map_pkg::none;
        end
    end

    // offset from the first led address, only meaningful in the led region
    assign led_index = mem_map_pkg::led_index_width'(addr - mem_map_pkg::led_first);

endmodule

`default_nettype wire

// File: hw/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

    // cpu and dram geometry
    localparam int word_width      = 16;
    localparam int dram_addr_width = 25;
    localparam int dram_pad_width  = dram_addr_width - word_width;

    // pixel address is x above y
    localparam int px_x_width       = 10;
    localparam int px_y_width       = 9;
    localparam int pixel_addr_width = px_x_width + px_y_width;
    localparam int pixel_pad_width  = dram_addr_width - pixel_addr_width;

    localparam int led_count       = 10;
    localparam int led_index_width = 4;

    // address map
    localparam logic [word_width-1:0] dram_last       = 16'hF7FF;
    localparam logic [word_width-1:0] led_first       = 16'hF800;
    localparam logic [word_width-1:0] led_last        = 16'hF809;
    localparam logic [word_width-1:0] uart_ready_addr = 16'hF80A;
    localparam logic [word_width-1:0] uart_byte_addr  = 16'hF80B;
    localparam logic [word_width-1:0] vga_addr        = 16'hF80C;

    localparam logic [word_width-1:0] nop_instr = 16'hF000;

    // serial line, 8N1
    localparam int clks_per_bit   = 4;
    localparam int baud_cnt_width = $clog2(clks_per_bit);
    localparam int uart_data_bits = 8;

    typedef enum logic [2:0] {
        idle,
        fetch_instr,
        wait_instr,
        instr_out,
        rw_data,
        wait_data,
        data_out
    } ctrl_state_t;

    typedef enum logic [2:0] {
        dram,
        led,
        uart_ready,
        uart_byte,
        vga,
        none
    } region_t;

    typedef enum logic [1:0] {
        px_x,
        px_y,
        px_colour
    } pixel_state_t;

endpackage

`default_nettype wire
